// File: common/int_pkg.sv
// Intersection unit shared definitions
`default_nettype none

package int_pkg;

  // signed Q16.16 fixed point
  typedef logic signed [31:0] fix_t;

  localparam int FRAC_BITS = 16;
  localparam fix_t FIX_ONE = 32'sh0001_0000;
  localparam fix_t FIX_MAX = 32'sh7fff_ffff;
  localparam fix_t FIX_MIN = 32'sh8000_0000;

  // pipeline latencies
  localparam int PRIME_LAT = 2;
  localparam int DIV_LAT = 32;
  // prime, divide, then multiply, add, bary sum and output register
  localparam int INT_LAT = PRIME_LAT + DIV_LAT + 4;

  // register map, byte offsets
  localparam int REG_ADDR_BITS = 8;
  localparam logic [REG_ADDR_BITS-1:0] REG_M11 = 8'h00;
  localparam logic [REG_ADDR_BITS-1:0] REG_M12 = 8'h04;
  localparam logic [REG_ADDR_BITS-1:0] REG_M13 = 8'h08;
  localparam logic [REG_ADDR_BITS-1:0] REG_M21 = 8'h0c;
  localparam logic [REG_ADDR_BITS-1:0] REG_M22 = 8'h10;
  localparam logic [REG_ADDR_BITS-1:0] REG_M23 = 8'h14;
  localparam logic [REG_ADDR_BITS-1:0] REG_M31 = 8'h18;
  localparam logic [REG_ADDR_BITS-1:0] REG_M32 = 8'h1c;
  localparam logic [REG_ADDR_BITS-1:0] REG_M33 = 8'h20;
  localparam logic [REG_ADDR_BITS-1:0] REG_TX = 8'h24;
  localparam logic [REG_ADDR_BITS-1:0] REG_TY = 8'h28;
  localparam logic [REG_ADDR_BITS-1:0] REG_TZ = 8'h2c;
  localparam logic [REG_ADDR_BITS-1:0] REG_EPS = 8'h30;

  localparam fix_t EPS_RESET = 32'sh0000_0010;

  // product truncated toward negative infinity
  function automatic fix_t fix_mul(fix_t a, fix_t b);
    logic signed [63:0] prod;
    prod = a * b;
    return fix_t'(prod >>> FRAC_BITS);
  endfunction

endpackage

`default_nettype wire

// File: verilog/delay_line.sv
// Fixed latency delay line
`default_nettype none

module delay_line #(
  parameter int depth = 1,
  parameter type payload_t = int_pkg::fix_t
) (
  input logic clk,
  input logic reset,
  input payload_t data_in,
  output payload_t data_out
);

  payload_t stage_q [depth];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_in;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_out = stage_q[depth-1];

endmodule

`default_nettype wire

// File: verilog/prime_calc.sv
// Ray transform for one matrix row
`default_nettype none

module prime_calc (
  input logic clk,
  input logic reset,
  input int_pkg::fix_t ray_ox,
  input int_pkg::fix_t ray_oy,
  input int_pkg::fix_t ray_oz,
  input int_pkg::fix_t ray_dx,
  input int_pkg::fix_t ray_dy,
  input int_pkg::fix_t ray_dz,
  input int_pkg::fix_t mk1,
  input int_pkg::fix_t mk2,
  input int_pkg::fix_t mk3,
  input int_pkg::fix_t tk,
  output int_pkg::fix_t originp,
  output int_pkg::fix_t dirp
);
  import int_pkg::*;

  fix_t org_p1, org_p2, org_p3;
  fix_t dir_p1, dir_p2, dir_p3;
  fix_t tk_q;

  // stage one, six products
  // translate is captured with the ray so later writes miss it
  always_ff @(posedge clk) begin
    org_p1 <= fix_mul(mk1, ray_ox);
    org_p2 <= fix_mul(mk2, ray_oy);
    org_p3 <= fix_mul(mk3, ray_oz);
    dir_p1 <= fix_mul(mk1, ray_dx);
    dir_p2 <= fix_mul(mk2, ray_dy);
    dir_p3 <= fix_mul(mk3, ray_dz);
    tk_q <= tk;
  end

  // stage two, row sums
  always_ff @(posedge clk) begin
    if (reset) begin
      originp <= '0;
      dirp <= '0;
    end else begin
      originp <= org_p1 + org_p2 + org_p3 + tk_q;
      dirp <= dir_p1 + dir_p2 + dir_p3;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fix_div.sv
// Pipelined fixed-point divider
`default_nettype none

module fix_div (
  input logic clk,
  input logic reset,
  input int_pkg::fix_t dividend,
  input int_pkg::fix_t divisor,
  output int_pkg::fix_t quotient
);
  import int_pkg::*;

  // one restoring step, returns {quotient bit, new remainder}
  function automatic logic [32:0] div_step(logic [31:0] rem, logic num_bit, logic [31:0] den);
    logic [32:0] trial;
    trial = {rem, num_bit};
    if (trial >= {1'b0, den}) begin
      trial = trial - {1'b0, den};
      return {1'b1, trial[31:0]};
    end
    return {1'b0, trial[31:0]};
  endfunction

  logic [31:0] a_mag, d_mag;
  logic q_neg, sat_in;
  logic [32:0] step [DIV_LAT];
  logic [31:0] q_mag;
  logic inexact;

  // per stage state, flags are {sat, dividend sign, quotient sign}
  logic [31:0] rem_q [DIV_LAT-1];
  logic [31:0] num_q [DIV_LAT-1];
  logic [31:0] den_q [DIV_LAT-1];
  logic [31:0] quo_q [DIV_LAT-1];
  logic [2:0] flag_q [DIV_LAT-1];

  always_comb begin
    a_mag = dividend[31] ? -dividend : dividend;
    d_mag = divisor[31] ? -divisor : divisor;
    q_neg = dividend[31] ^ divisor[31];
    // quotient of (a << 16) / d reaches 2^31 exactly when a >= d << 15
    sat_in = (d_mag == '0) || ({15'b0, a_mag} >= {d_mag, 15'b0});
    // upper sixteen numerator bits are always below the divisor here
    step[0] = div_step({16'b0, a_mag[31:16]}, a_mag[15], d_mag);
    for (int s = 1; s < DIV_LAT; s++) begin
      step[s] = div_step(rem_q[s-1], num_q[s-1][31], den_q[s-1]);
    end
    q_mag = {quo_q[DIV_LAT-2][30:0], step[DIV_LAT-1][32]};
    inexact = step[DIV_LAT-1][31:0] != '0;
  end

  always_ff @(posedge clk) begin
    rem_q[0] <= step[0][31:0];
    num_q[0] <= {a_mag[14:0], 17'b0};
    den_q[0] <= d_mag;
    quo_q[0] <= {31'b0, step[0][32]};
    for (int s = 1; s < DIV_LAT-1; s++) begin
      rem_q[s] <= step[s][31:0];
      num_q[s] <= {num_q[s-1][30:0], 1'b0};
      den_q[s] <= den_q[s-1];
      quo_q[s] <= {quo_q[s-1][30:0], step[s][32]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < DIV_LAT-1; s++) begin
        flag_q[s] <= '0;
      end
      quotient <= '0;
    end else begin
      flag_q[0] <= {sat_in, dividend[31], q_neg};
      for (int s = 1; s < DIV_LAT-1; s++) begin
        flag_q[s] <= flag_q[s-1];
      end
      if (flag_q[DIV_LAT-2][2]) begin
        quotient <= flag_q[DIV_LAT-2][1] ? FIX_MIN : FIX_MAX;
      end else if (flag_q[DIV_LAT-2][0]) begin
        // floor for negative results
        quotient <= inexact ? fix_t'(~q_mag) : fix_t'(-q_mag);
      end else begin
        quotient <= fix_t'(q_mag);
      end
    end
  end

endmodule

`default_nettype wire

// File: int_math/int_math.sv
// Ray triangle intersection datapath
`default_nettype none

module int_math (
  input logic clk,
  input logic reset,
  input logic ray_valid,
  input int_pkg::fix_t ray_ox,
  input int_pkg::fix_t ray_oy,
  input int_pkg::fix_t ray_oz,
  input int_pkg::fix_t ray_dx,
  input int_pkg::fix_t ray_dy,
  input int_pkg::fix_t ray_dz,
  input int_pkg::fix_t m11,
  input int_pkg::fix_t m12,
  input int_pkg::fix_t m13,
  input int_pkg::fix_t m21,
  input int_pkg::fix_t m22,
  input int_pkg::fix_t m23,
  input int_pkg::fix_t m31,
  input int_pkg::fix_t m32,
  input int_pkg::fix_t m33,
  input int_pkg::fix_t tx,
  input int_pkg::fix_t ty,
  input int_pkg::fix_t tz,
  input int_pkg::fix_t eps,
  output logic hit_valid,
  output logic hit,
  output int_pkg::fix_t t_int,
  output int_pkg::fix_t u,
  output int_pkg::fix_t v
);
  import int_pkg::*;

  fix_t originp_x, originp_y, originp_z;
  fix_t dirp_x, dirp_y, dirp_z;
  fix_t dirp_z_abs, t_div;
  fix_t originp_x_d, originp_y_d, dirp_x_d, dirp_y_d;
  fix_t mul_x, mul_y, u_add, v_add;
  fix_t u_bary, v_bary, uv_sum;
  fix_t t_d, eps_d;
  logic valid_d;

  // transform into triangle unit space, one row each
  prime_calc pc_x (
    .clk, .reset, .ray_ox, .ray_oy, .ray_oz, .ray_dx, .ray_dy, .ray_dz,
    .mk1(m11), .mk2(m12), .mk3(m13), .tk(tx),
    .originp(originp_x), .dirp(dirp_x)
  );

  prime_calc pc_y (
    .clk, .reset, .ray_ox, .ray_oy, .ray_oz, .ray_dx, .ray_dy, .ray_dz,
    .mk1(m21), .mk2(m22), .mk3(m23), .tk(ty),
    .originp(originp_y), .dirp(dirp_y)
  );

  prime_calc pc_z (
    .clk, .reset, .ray_ox, .ray_oy, .ray_oz, .ray_dx, .ray_dy, .ray_dz,
    .mk1(m31), .mk2(m32), .mk3(m33), .tk(tz),
    .originp(originp_z), .dirp(dirp_z)
  );

  // t = originp_z / |dirp_z|
  assign dirp_z_abs = dirp_z[31] ? -dirp_z : dirp_z;

  fix_div div (.clk, .reset, .dividend(originp_z), .divisor(dirp_z_abs), .quotient(t_div));

  // origins wait through the divider and the multiply stage
  delay_line #(.depth(DIV_LAT + 1)) ox_dl (.clk, .reset, .data_in(originp_x), .data_out(originp_x_d));
  delay_line #(.depth(DIV_LAT + 1)) oy_dl (.clk, .reset, .data_in(originp_y), .data_out(originp_y_d));
  delay_line #(.depth(DIV_LAT)) dx_dl (.clk, .reset, .data_in(dirp_x), .data_out(dirp_x_d));
  delay_line #(.depth(DIV_LAT)) dy_dl (.clk, .reset, .data_in(dirp_y), .data_out(dirp_y_d));

  // multiply, add and bary stages
  delay_line #(.depth(3)) t_dl (.clk, .reset, .data_in(t_div), .data_out(t_d));

  // epsilon travels with its ray
  delay_line #(.depth(INT_LAT - 1)) eps_dl (.clk, .reset, .data_in(eps), .data_out(eps_d));

  delay_line #(.depth(INT_LAT - 1), .payload_t(logic)) valid_dl (
    .clk, .reset, .data_in(ray_valid), .data_out(valid_d)
  );

  always_ff @(posedge clk) begin
    mul_x <= fix_mul(dirp_x_d, t_div);
    mul_y <= fix_mul(dirp_y_d, t_div);
    u_add <= originp_x_d + mul_x;
    v_add <= originp_y_d + mul_y;
    uv_sum <= u_add + v_add;
    u_bary <= u_add;
    v_bary <= v_add;
  end

  // output register, compares on the aligned values
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_valid <= 1'b0;
      hit <= 1'b0;
    end else begin
      hit_valid <= valid_d;
      hit <= valid_d && (uv_sum < FIX_ONE) && (t_d > eps_d) && !u_bary[31] && !v_bary[31];
    end
  end

  always_ff @(posedge clk) begin
    t_int <= t_d;
    u <= u_bary;
    v <= v_bary;
  end

endmodule

`default_nettype wire

// File: verilog/tri_regs_apb.sv
// Triangle register bank on APB
`default_nettype none

module tri_regs_apb (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [int_pkg::REG_ADDR_BITS-1:0] paddr,
  input int_pkg::fix_t pwdata,
  output int_pkg::fix_t prdata,
  output logic pready,
  output logic pslverr,
  output int_pkg::fix_t m11,
  output int_pkg::fix_t m12,
  output int_pkg::fix_t m13,
  output int_pkg::fix_t m21,
  output int_pkg::fix_t m22,
  output int_pkg::fix_t m23,
  output int_pkg::fix_t m31,
  output int_pkg::fix_t m32,
  output int_pkg::fix_t m33,
  output int_pkg::fix_t tx,
  output int_pkg::fix_t ty,
  output int_pkg::fix_t tz,
  output int_pkg::fix_t eps
);
  import int_pkg::*;

  logic access, addr_ok;

  assign access = psel && penable;
  assign addr_ok = (paddr[1:0] == 2'b00) && (paddr <= REG_EPS);

  // no wait states
  assign pready = access;
  assign pslverr = access && !addr_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      {m11, m12, m13, m21, m22, m23, m31, m32, m33} <= '0;
      {tx, ty, tz} <= '0;
      eps <= EPS_RESET;
    end else if (access && pwrite) begin
      case (paddr)
        REG_M11: m11 <= pwdata;
        REG_M12: m12 <= pwdata;
        REG_M13: m13 <= pwdata;
        REG_M21: m21 <= pwdata;
        REG_M22: m22 <= pwdata;
        REG_M23: m23 <= pwdata;
        REG_M31: m31 <= pwdata;
        REG_M32: m32 <= pwdata;
        REG_M33: m33 <= pwdata;
        REG_TX: tx <= pwdata;
        REG_TY: ty <= pwdata;
        REG_TZ: tz <= pwdata;
        REG_EPS: eps <= pwdata;
        default: ;
      endcase
    end
  end

  // readback, zero outside a valid read access
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        REG_M11: prdata = m11;
        REG_M12: prdata = m12;
        REG_M13: prdata = m13;
        REG_M21: prdata = m21;
        REG_M22: prdata = m22;
        REG_M23: prdata = m23;
        REG_M31: prdata = m31;
        REG_M32: prdata = m32;
        REG_M33: prdata = m33;
        REG_TX: prdata = tx;
        REG_TY: prdata = ty;
        REG_TZ: prdata = tz;
        REG_EPS: prdata = eps;
        default: prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/int_unit_top.sv
// Intersection unit top level
`default_nettype none

module int_unit_top (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic [int_pkg::REG_ADDR_BITS-1:0] paddr,
  input int_pkg::fix_t pwdata,
  output int_pkg::fix_t prdata,
  output logic pready,
  output logic pslverr,
  input logic ray_valid,
  input int_pkg::fix_t ray_ox,
  input int_pkg::fix_t ray_oy,
  input int_pkg::fix_t ray_oz,
  input int_pkg::fix_t ray_dx,
  input int_pkg::fix_t ray_dy,
  input int_pkg::fix_t ray_dz,
  output logic hit_valid,
  output logic hit,
  output int_pkg::fix_t t_int,
  output int_pkg::fix_t u,
  output int_pkg::fix_t v
);
  import int_pkg::*;

  // triangle registers into the datapath
  fix_t m11, m12, m13, m21, m22, m23, m31, m32, m33;
  fix_t tx, ty, tz, eps;

  tri_regs_apb regs (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .m11, .m12, .m13, .m21, .m22, .m23, .m31, .m32, .m33,
    .tx, .ty, .tz, .eps
  );

  int_math math (
    .clk, .reset, .ray_valid,
    .ray_ox, .ray_oy, .ray_oz, .ray_dx, .ray_dy, .ray_dz,
    .m11, .m12, .m13, .m21, .m22, .m23, .m31, .m32, .m33,
    .tx, .ty, .tz, .eps,
    .hit_valid, .hit, .t_int, .u, .v
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock
`default_nettype none

module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  localparam time HALF_PERIOD = 10ns;

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: tests/int_unit_assertions.sv
// Intersection unit checker
`default_nettype none

module int_unit_assertions (
  input logic clk,
  input logic reset,
  input logic ray_valid,
  input int_pkg::fix_t ray_ox, ray_oy, ray_oz, ray_dx, ray_dy, ray_dz,
  input int_pkg::fix_t m11, m12, m13, m21, m22, m23, m31, m32, m33,
  input int_pkg::fix_t tx, ty, tz, eps,
  input logic hit_valid,
  input logic hit,
  input int_pkg::fix_t t_int, u, v
);
  timeunit 1ns;
  timeprecision 1ps;
  import int_pkg::*;

  int fail_count = 0;
  logic exp_valid [INT_LAT];
  logic [96:0] exp_res [INT_LAT];
  logic exp_vld, exp_hit;
  fix_t exp_t, exp_u, exp_v;

  // product, low 16 bits dropped
  function automatic fix_t q_mul(fix_t a, fix_t b);
    logic signed [63:0] full;
    full = a * b;
    return full[47:16];
  endfunction

  // floor of (num << 16) / den, saturated by the dividend's sign
  function automatic fix_t q_div(fix_t num, fix_t den);
    logic signed [63:0] n, d, q;
    logic [63:0] n_mag, d_mag, q_mag, r_mag;
    n = num;
    n = n <<< FRAC_BITS;
    d = den;
    n_mag = (n < 0) ? -n : n;
    d_mag = (d < 0) ? -d : d;
    if (d_mag == 0) begin
      return (num < 0) ? FIX_MIN : FIX_MAX;
    end
    q_mag = n_mag / d_mag;
    r_mag = n_mag % d_mag;
    if (q_mag >= 64'h8000_0000) begin
      return (num < 0) ? FIX_MIN : FIX_MAX;
    end
    q = $signed(q_mag);
    if ((num < 0) != (den < 0)) begin
      q = (r_mag != 0) ? -q - 1 : -q;
    end
    return q[31:0];
  endfunction

  // returns {hit, t, u, v}
  function automatic logic [96:0] intersect_model(fix_t mat [9], fix_t tr [3], fix_t eps_val,
                                                  fix_t org [3], fix_t dir [3]);
    fix_t op [3];
    fix_t dp [3];
    fix_t dz_mag, t_val, u_val, v_val, uv;
    logic hit_val;
    for (int r = 0; r < 3; r++) begin
      op[r] = q_mul(mat[3*r], org[0]) + q_mul(mat[3*r+1], org[1])
              + q_mul(mat[3*r+2], org[2]) + tr[r];
      dp[r] = q_mul(mat[3*r], dir[0]) + q_mul(mat[3*r+1], dir[1]) + q_mul(mat[3*r+2], dir[2]);
    end
    dz_mag = (dp[2] < 0) ? -dp[2] : dp[2];
    t_val = q_div(op[2], dz_mag);
    u_val = op[0] + q_mul(dp[0], t_val);
    v_val = op[1] + q_mul(dp[1], t_val);
    uv = u_val + v_val;
    hit_val = (uv < FIX_ONE) && (t_val > eps_val) && (u_val >= 0) && (v_val >= 0);
    return {hit_val, t_val, u_val, v_val};
  endfunction

  // expected results, computed from what the ray cycle saw
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < INT_LAT; i++) begin
        exp_valid[i] <= 1'b0;
      end
    end else begin
      exp_valid[0] <= ray_valid;
      exp_res[0] <= intersect_model('{m11, m12, m13, m21, m22, m23, m31, m32, m33},
                                    '{tx, ty, tz}, eps, '{ray_ox, ray_oy, ray_oz},
                                    '{ray_dx, ray_dy, ray_dz});
      for (int i = 1; i < INT_LAT; i++) begin
        exp_valid[i] <= exp_valid[i-1];
        exp_res[i] <= exp_res[i-1];
      end
    end
  end

  assign exp_vld = exp_valid[INT_LAT-1];
  assign exp_hit = exp_res[INT_LAT-1][96];
  assign exp_t = exp_res[INT_LAT-1][95:64];
  assign exp_u = exp_res[INT_LAT-1][63:32];
  assign exp_v = exp_res[INT_LAT-1][31:0];

  valid_latency: assert property (@(posedge clk) disable iff (reset) hit_valid == exp_vld)
    else begin
      fail_count++;
      $error("mismatch at %0t: hit_valid %b, expected %b", $time, $sampled(hit_valid),
             $sampled(exp_vld));
    end

  hit_result: assert property (@(posedge clk) disable iff (reset) hit_valid |-> hit == exp_hit)
    else begin
      fail_count++;
      $error("mismatch at %0t: hit %b, expected %b", $time, $sampled(hit), $sampled(exp_hit));
    end

  hit_idle: assert property (@(posedge clk) disable iff (reset) !hit_valid |-> !hit)
    else begin
      fail_count++;
      $error("mismatch at %0t: hit high without hit_valid", $time);
    end

  coord_result: assert property (@(posedge clk) disable iff (reset)
    hit_valid |-> (t_int == exp_t) && (u == exp_u) && (v == exp_v))
    else begin
      fail_count++;
      $error("mismatch at %0t: t %h u %h v %h, expected %h %h %h", $time, $sampled(t_int),
             $sampled(u), $sampled(v), $sampled(exp_t), $sampled(exp_u), $sampled(exp_v));
    end

endmodule

`default_nettype wire

// File: tests/tb_int_unit.sv
// Intersection unit testbench
`default_nettype none

module tb_int_unit;
  timeunit 1ns;
  timeprecision 1ps;
  import int_pkg::*;

  localparam int NUM_RAND_RAYS = 24;
  localparam int NUM_FLIGHT_RAYS = 14;
  localparam int NUM_RAYS = 2 * NUM_RAND_RAYS + 10 + NUM_FLIGHT_RAYS;
  localparam int NUM_APB = 75;
  // four cycles per ray or transfer, plus the pipeline drain
  localparam int WATCHDOG_CYCLES = (NUM_RAYS + NUM_APB + INT_LAT) * 4;

  logic clk, reset;
  logic psel, penable, pwrite;
  logic [REG_ADDR_BITS-1:0] paddr;
  fix_t pwdata, prdata;
  logic pready, pslverr;
  logic ray_valid;
  fix_t ray_ox, ray_oy, ray_oz, ray_dx, ray_dy, ray_dz;
  logic hit_valid, hit;
  fix_t t_int, u, v;

  logic [31:0] lfsr_state = 32'h03af_0920;
  fix_t reg_model [13];
  int rays_sent = 0;
  int results_seen = 0;

  tb_clock clock_gen (.clk);

  int_unit_top uut (.*);

  bind int_unit_top int_unit_assertions chk (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // sign extended n bit value
  function automatic fix_t random_fix(int nbits);
    logic [31:0] raw;
    raw = random_bits(nbits) << (32 - nbits);
    return $signed(raw) >>> (32 - nbits);
  endfunction

  task automatic apb_transfer(input logic write, input logic [REG_ADDR_BITS-1:0] addr,
                              input fix_t wdata, output fix_t rdata, output logic err);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    if (!pready) begin
      abort_run("pready was low in an APB access cycle");
    end
    rdata = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic write_reg(input logic [REG_ADDR_BITS-1:0] addr, input fix_t data);
    fix_t rd;
    logic err;
    apb_transfer(1'b1, addr, data, rd, err);
    if (err) begin
      abort_run($sformatf("unexpected pslverr writing 0x%02h", addr));
    end
    reg_model[addr[7:2]] = data;
  endtask

  task automatic read_reg(input logic [REG_ADDR_BITS-1:0] addr);
    fix_t rd;
    logic err;
    apb_transfer(1'b0, addr, '0, rd, err);
    if (err) begin
      abort_run($sformatf("unexpected pslverr reading 0x%02h", addr));
    end else if (rd !== reg_model[addr[7:2]]) begin
      abort_run($sformatf("mismatch at %0t: read 0x%02h gave %h, expected %h", $time, addr,
                          rd, reg_model[addr[7:2]]));
    end
  endtask

  // bad address must flag pslverr and read as zero
  task automatic access_bad(input logic write, input logic [REG_ADDR_BITS-1:0] addr);
    fix_t rd;
    logic err;
    apb_transfer(write, addr, random_fix(32), rd, err);
    if (!err) begin
      abort_run($sformatf("no pslverr for bad address 0x%02h", addr));
    end else if (rd !== '0) begin
      abort_run($sformatf("mismatch at %0t: bad read 0x%02h gave %h", $time, addr, rd));
    end
  endtask

  task automatic load_triangle(input fix_t mat [9], input fix_t tr [3], input fix_t eps_val);
    for (int i = 0; i < 9; i++) begin
      write_reg(8'(REG_M11 + 4 * i), mat[i]);
    end
    for (int i = 0; i < 3; i++) begin
      write_reg(8'(REG_TX + 4 * i), tr[i]);
    end
    write_reg(REG_EPS, eps_val);
  endtask

  task automatic send_ray(input fix_t ox, oy, oz, dx, dy, dz);
    @(negedge clk);
    ray_valid = 1'b1;
    ray_ox = ox;
    ray_oy = oy;
    ray_oz = oz;
    ray_dx = dx;
    ray_dy = dy;
    ray_dz = dz;
    rays_sent++;
  endtask

  task automatic stop_rays();
    @(negedge clk);
    ray_valid = 1'b0;
  endtask

  task automatic send_random_ray();
    fix_t ox, oy, oz, dx, dy, dz;
    ox = random_fix(17);
    oy = random_fix(17);
    oz = random_fix(20);
    dx = random_fix(16);
    dy = random_fix(16);
    dz = random_fix(19);
    send_ray(ox, oy, oz, dx, dy, dz);
  endtask

  // back to back rays with random gaps
  task automatic send_random_rays(input int count);
    for (int i = 0; i < count; i++) begin
      send_random_ray();
      if (random_bits(1) == 1) begin
        stop_rays();
      end
    end
    stop_rays();
  endtask

  always @(negedge clk) begin
    if (!reset && hit_valid) begin
      results_seen++;
    end
  end

  always @(uut.chk.fail_count) begin
    if (uut.chk.fail_count != 0) begin
      abort_run("the checker reported a wrong result");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("timeout, the run did not finish in time");
  end

  initial begin
    fix_t rand_m [9];
    fix_t rand_t [3];
    fix_t flight_data [4];
    reset = 1'b1;
    {psel, penable, pwrite, ray_valid} = '0;
    paddr = '0;
    pwdata = '0;
    {ray_ox, ray_oy, ray_oz, ray_dx, ray_dy, ray_dz} = '0;
    foreach (reg_model[i]) reg_model[i] = '0;
    reg_model[12] = EPS_RESET;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // reset values, then write and read back each register
    for (int i = 0; i < 13; i++) read_reg(8'(4 * i));
    for (int i = 0; i < 13; i++) write_reg(8'(4 * i), random_fix(32));
    for (int i = 0; i < 13; i++) read_reg(8'(4 * i));
    access_bad(1'b1, 8'h34);
    access_bad(1'b0, 8'h34);
    access_bad(1'b1, 8'h05);
    access_bad(1'b0, 8'h06);
    read_reg(8'h04);

    load_triangle('{FIX_ONE, 0, 0, 0, FIX_ONE, 0, 0, 0, FIX_ONE}, '{0, 0, 0}, EPS_RESET);
    send_random_rays(NUM_RAND_RAYS);

    // hit boundaries, unit direction so t equals oz
    write_reg(REG_EPS, 32'sh100);
    send_ray(-1, 32'sh1000, FIX_ONE, 0, 0, FIX_ONE);
    send_ray(0, 32'sh1000, FIX_ONE, 0, 0, FIX_ONE);
    send_ray(32'sh1000, -1, FIX_ONE, 0, 0, FIX_ONE);
    send_ray(32'sh1000, 0, FIX_ONE, 0, 0, FIX_ONE);
    send_ray(32'sh8000, 32'sh8000, FIX_ONE, 0, 0, FIX_ONE);
    send_ray(32'sh8000, 32'sh7fff, FIX_ONE, 0, 0, FIX_ONE);
    send_ray(32'sh1000, 32'sh1000, 32'sh100, 0, 0, FIX_ONE);
    send_ray(32'sh1000, 32'sh1000, 32'sh101, 0, 0, FIX_ONE);
    // zero direction z saturates t
    send_ray(32'sh4000, 32'sh4000, -FIX_ONE, 0, 0, 0);
    send_ray(32'sh4000, 32'sh4000, FIX_ONE, 0, 0, 0);
    stop_rays();

    for (int i = 0; i < 9; i++) rand_m[i] = random_fix(18);
    for (int i = 0; i < 3; i++) rand_t[i] = random_fix(18);
    load_triangle(rand_m, rand_t, fix_t'(random_bits(12)));
    send_random_rays(NUM_RAND_RAYS);

    // rewrite the triangle while an unbroken ray burst streams in
    for (int i = 0; i < 4; i++) flight_data[i] = random_fix(18);
    fork
      begin
        write_reg(REG_M11, flight_data[0]);
        write_reg(REG_M33, flight_data[1]);
        write_reg(REG_TZ, flight_data[2]);
        write_reg(REG_EPS, flight_data[3]);
      end
      begin
        repeat (NUM_FLIGHT_RAYS) send_random_ray();
        stop_rays();
      end
    join

    wait (results_seen == rays_sent);
    repeat (4) @(negedge clk);
    if (uut.chk.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("the checker recorded failures");
    end
  end

endmodule

`default_nettype wire

// File: tb.f
common/int_pkg.sv
verilog/delay_line.sv
verilog/prime_calc.sv
verilog/fix_div.sv
int_math/int_math.sv
verilog/tri_regs_apb.sv
verilog/int_unit_top.sv
tests/tb_clock.sv
tests/int_unit_assertions.sv
tests/tb_int_unit.sv

// File: Bender.yml
package:
  name: int_unit

sources:
  - common/int_pkg.sv
  - verilog/delay_line.sv
  - verilog/prime_calc.sv
  - verilog/fix_div.sv
  - int_math/int_math.sv
  - verilog/tri_regs_apb.sv
  - verilog/int_unit_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/int_unit_assertions.sv
      - tests/tb_int_unit.sv
